/* flist.f */
+incdir+verilog
verilog/floor_pkg.sv
verilog/car_pkg.sv
verilog/request_latch.sv
verilog/car_dispatcher.sv
verilog/floor_request_controller.sv
tb/clock_reset_gen.sv
tb/tb_floor_request_controller.sv

/* tb/clock_reset_gen.sv */
/*
 * Testbench clock and reset source
 * 10 ns clock, active-low reset held over the first three rising edges
 */

`timescale 1ns/1ps

module clock_reset_gen (
    output logic clock,
    output logic reset_n
);

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    // Released on the third rising edge so the DUT sees three reset edges
    initial begin
        reset_n = 1'b0;
        repeat (3) @(posedge clock);
        reset_n <= 1'b1;
    end

endmodule

/* tb/tb_floor_request_controller.sv */
/*
 * Testbench for the floor request controller
 * Directed and random stimulus, a cycle model of the request and SCAN rules,
 * and a per-cycle comparison of every DUT output
 */

`timescale 1ns/1ps

`include "elevator_macros.svh"

module tb_floor_request_controller
    import floor_pkg::*;
    import car_pkg::*;
;

    localparam int RESET_CYCLES    = 3;
    localparam int DIRECTED_CYCLES = 150;
    localparam int RANDOM_CYCLES   = 400;
    localparam int TOTAL_CYCLES    = RESET_CYCLES + DIRECTED_CYCLES + RANDOM_CYCLES;
    localparam int TIMEOUT_NS      = 2 * TOTAL_CYCLES * 10;

    // Expected register contents of the whole controller
    typedef struct packed {
        floor_mask_t hall;
        floor_mask_t cab;
        direction_t  dir;
        floor_t      target;
        logic        activate;
        logic        open_allowed;
        logic        close_allowed;
    } model_t;

    logic         clock;
    logic         reset_n;
    floor_mask_t  hall_calls;
    floor_mask_t  cab_calls;
    car_status_t  car_status;
    panel_ctrl_t  panel;
    floor_mask_t  hall_lights;
    floor_mask_t  cab_lights;
    car_command_t command;
    door_permit_t doors;

    model_t       expected;
    model_t       pending;
    logic         model_valid = 1'b0;
    string        test_name   = "reset";
    logic [31:0]  rand_state  = 32'd60128;

    clock_reset_gen clock_gen (
        .clock   (clock),
        .reset_n (reset_n)
    );

    floor_request_controller dut (
        .clock       (clock),
        .reset_n     (reset_n),
        .hall_calls  (hall_calls),
        .cab_calls   (cab_calls),
        .car_status  (car_status),
        .panel       (panel),
        .hall_lights (hall_lights),
        .cab_lights  (cab_lights),
        .command     (command),
        .doors       (doors)
    );

    //////////////////////////////
    // Helpers
    //////////////////////////////

    function automatic logic [31:0] lcg_next();
        rand_state = rand_state * 32'd1664525 + 32'd1013904223;
        return rand_state;
    endfunction

    task automatic check_value(input string what, input logic [15:0] exp_val,
                               input logic [15:0] act_val);
        if (exp_val !== act_val) begin
            $display("mismatch in %s: %s expected 0x%0h, actual 0x%0h",
                     test_name, what, exp_val, act_val);
            $display("Simulation finished: FAIL");
            $fatal(1, "Stopping at the first error");
        end
    endtask

    // Next register state from the current state and the inputs at one edge
    function automatic model_t predict(input model_t prior, input floor_mask_t hall_btn,
                                       input floor_mask_t cab_btn, input car_status_t status,
                                       input panel_ctrl_t pnl);
        model_t      nxt;
        floor_mask_t req;
        floor_mask_t press_ok;
        floor_mask_t clr;
        logic        live;
        logic        stopped;
        logic        above;
        logic        below;
        logic        found;
        floor_t      tgt;
        int          cf;

        nxt      = prior;
        cf       = status.current_floor;
        live     = pnl.power_on && !pnl.emergency;
        stopped  = !status.moving;
        req      = prior.hall | prior.cab;
        above    = 1'b0;
        below    = 1'b0;
        press_ok = '0;
        clr      = '0;
        for (int f = 0; f < `NUM_FLOORS; f++) begin
            if (req[f] && f > cf) above = 1'b1;
            if (req[f] && f < cf) below = 1'b1;
            press_ok[f] = live && (f != cf);
            clr[f]      = stopped && pnl.power_on && (f == cf);
        end
        nxt.hall = (prior.hall | (hall_btn & press_ok)) & ~clr;
        nxt.cab  = (prior.cab | (cab_btn & press_ok)) & ~clr;

        tgt   = status.current_floor;
        found = 1'b0;
        if (stopped) begin
            if (prior.dir == DIR_UP && !above && below) nxt.dir = DIR_DOWN;
            else if (prior.dir == DIR_DOWN && !below && above) nxt.dir = DIR_UP;
            if (nxt.dir == DIR_UP) begin
                for (int f = cf + 1; f <= `TOP_FLOOR; f++) begin
                    if (!found && req[f]) begin
                        tgt   = floor_t'(f);
                        found = 1'b1;
                    end
                end
            end else begin
                for (int f = cf - 1; f >= 0; f--) begin
                    if (!found && req[f]) begin
                        tgt   = floor_t'(f);
                        found = 1'b1;
                    end
                end
            end
            nxt.target = tgt;
        end
        nxt.activate      = live && stopped && (tgt != status.current_floor);
        nxt.open_allowed  = stopped && pnl.power_on && pnl.door_open_btn;
        nxt.close_allowed = stopped && pnl.power_on && pnl.door_close_btn;
        return nxt;
    endfunction

    //////////////////////////////
    // Model and comparison
    //////////////////////////////

    // Model registers follow the DUT clock edge, reset included
    always @(posedge clock) begin : model_advance
        if (!reset_n) begin
            expected     = '0;
            expected.dir = DIR_UP;
        end else begin
            expected = pending;
        end
        model_valid = 1'b1;
    end

    // Outputs and inputs are both settled at the falling edge
    always @(negedge clock) begin : compare_outputs
        if (model_valid) begin
            check_value("hall_lights", expected.hall, hall_lights);
            check_value("cab_lights", expected.cab, cab_lights);
            check_value("direction", expected.dir, command.direction);
            check_value("target_floor", expected.target, command.target_floor);
            check_value("activate", expected.activate, command.activate);
            check_value("open_allowed", expected.open_allowed, doors.open_allowed);
            check_value("close_allowed", expected.close_allowed, doors.close_allowed);
            pending = predict(expected, hall_calls, cab_calls, car_status, panel);
        end
    end

    //////////////////////////////
    // Stimulus tasks
    //////////////////////////////

    // Let the edges pass, then settle at the falling edge
    task automatic idle(input int cycles);
        repeat (cycles) @(posedge clock);
        @(negedge clock);
    endtask

    // One-cycle button pulse
    task automatic press(input floor_mask_t hall, input floor_mask_t cab);
        @(posedge clock);
        hall_calls <= hall;
        cab_calls  <= cab;
        @(posedge clock);
        hall_calls <= '0;
        cab_calls  <= '0;
    endtask

    task automatic set_car(input int floor, input logic mv);
        @(posedge clock);
        car_status.current_floor <= floor_t'(floor);
        car_status.moving        <= mv;
    endtask

    task automatic set_panel(input logic pwr, input logic emer, input logic open_btn,
                             input logic close_btn);
        @(posedge clock);
        panel.power_on       <= pwr;
        panel.emergency      <= emer;
        panel.door_open_btn  <= open_btn;
        panel.door_close_btn <= close_btn;
    endtask

    //////////////////////////////
    // Directed and random tests
    //////////////////////////////

    initial begin : stimulus
        logic [31:0] r;

        hall_calls     = '0;
        cab_calls      = '0;
        car_status     = '0;
        panel          = '0;
        panel.power_on = 1'b1;

        wait (reset_n === 1'b1);
        @(negedge clock);
        check_value("reset lights", 16'h0, hall_lights | cab_lights);
        check_value("reset activate", 16'h0, command.activate);
        check_value("reset target", 16'h0, command.target_floor);
        check_value("reset direction", DIR_UP, command.direction);
        check_value("reset doors", 16'h0, doors);

        test_name = "latching";
        set_car(3, 1'b0);
        press(11'b000_0000_1010, 11'b000_1000_0000);
        idle(2);
        check_value("hall after press", 16'h002, hall_lights);
        check_value("cab after press", 16'h080, cab_lights);
        set_panel(1'b0, 1'b0, 1'b0, 1'b0);
        press(11'b010_0000_0000, '0);
        idle(2);
        check_value("hall with power off", 16'h002, hall_lights);
        set_panel(1'b1, 1'b1, 1'b0, 1'b0);
        press('0, 11'b001_0000_0000);
        idle(2);
        check_value("cab in emergency", 16'h080, cab_lights);
        set_panel(1'b1, 1'b0, 1'b0, 1'b0);

        test_name = "scan";
        idle(2);
        check_value("target going up", 16'd7, command.target_floor);
        check_value("activate going up", 16'h1, command.activate);
        press(11'b000_0010_0000, '0);
        idle(2);
        check_value("nearest above", 16'd5, command.target_floor);
        set_car(3, 1'b1);
        set_car(4, 1'b1);
        set_car(5, 1'b1);
        set_car(5, 1'b0);
        idle(3);
        check_value("hall after stop at 5", 16'h002, hall_lights);
        check_value("target after stop at 5", 16'd7, command.target_floor);
        set_car(6, 1'b1);
        set_car(7, 1'b1);
        set_car(7, 1'b0);
        idle(3);
        check_value("reversed direction", DIR_DOWN, command.direction);
        check_value("target going down", 16'd1, command.target_floor);
        press(11'b010_0000_0000, '0);
        idle(2);
        check_value("direction kept", DIR_DOWN, command.direction);

        test_name = "arrival clear";
        press(11'b000_0100_0000, 11'b000_0100_0000);
        idle(2);
        check_value("hall before arrival", 16'h242, hall_lights);
        set_car(6, 1'b1);
        set_car(6, 1'b0);
        idle(2);
        check_value("hall after arrival", 16'h202, hall_lights);
        check_value("cab after arrival", 16'h000, cab_lights);

        test_name = "door permits";
        set_panel(1'b1, 1'b0, 1'b1, 1'b0);
        idle(2);
        check_value("open while stopped", 16'h1, doors.open_allowed);
        set_car(6, 1'b1);
        idle(2);
        check_value("open while moving", 16'h0, doors.open_allowed);
        set_car(6, 1'b0);
        set_panel(1'b0, 1'b0, 1'b1, 1'b1);
        idle(2);
        check_value("doors with power off", 16'h0, doors);
        set_panel(1'b1, 1'b0, 1'b0, 1'b1);
        idle(2);
        check_value("close while stopped", 16'h1, doors.close_allowed);
        set_panel(1'b1, 1'b0, 1'b0, 1'b0);

        // Sparse buttons, mostly powered, occasional motion and emergency
        test_name = "random";
        repeat (RANDOM_CYCLES) begin
            @(posedge clock);
            r = lcg_next();
            hall_calls               <= floor_mask_t'((lcg_next() & lcg_next()) >> 16);
            cab_calls                <= floor_mask_t'((lcg_next() & lcg_next()) >> 16);
            car_status.current_floor <= floor_t'((lcg_next() >> 16) % `NUM_FLOORS);
            car_status.moving        <= (r[19:18] == 2'b00);
            panel.power_on           <= (r[23:21] != 3'b000);
            panel.emergency          <= (r[27:24] == 4'b0000);
            panel.door_open_btn      <= r[28];
            panel.door_close_btn     <= r[29];
        end
        idle(3);

        $display("Simulation finished: PASS");
        $finish;
    end

    initial begin : watchdog
        #(TIMEOUT_NS);
        $display("Watchdog expired before the tests completed");
        $display("Simulation finished: FAIL");
        $fatal(1, "Run timed out");
    end

endmodule

/* verilog/car_dispatcher.sv */
/*
 * Car dispatcher
 * SCAN target choice over the merged request lights, direction machine,
 * activate strobe, arrival clear and door permits
 */

`timescale 1ns/1ps

`include "elevator_macros.svh"

module car_dispatcher
    import floor_pkg::*;
    import car_pkg::*;
(
    input  logic         clock,
    input  logic         reset_n,
    input  floor_mask_t  hall_lights,
    input  floor_mask_t  cab_lights,
    input  car_status_t  car_status,
    input  panel_ctrl_t  panel,
    output floor_mask_t  service_clear,
    output car_command_t command,
    output door_permit_t doors
);

    floor_mask_t requests;
    floor_t      current_floor;
    logic        moving;
    logic        stopped_powered;
    logic        any_above;
    logic        any_below;
    direction_t  dir_state;
    direction_t  next_dir;
    floor_t      target_q;
    floor_t      next_target;
    logic        activate_q;
    logic        next_activate;

    // Hall and cab calls are served alike
    assign requests      = hall_lights | cab_lights;
    assign current_floor = car_status.current_floor;
    assign moving        = car_status.moving;

    // Car parked with power applied
    assign stopped_powered = !moving && panel.power_on;

    //////////////////////////////
    // Requests around the car
    //////////////////////////////

    always_comb begin : scan_ahead
        any_above = 1'b0;
        any_below = 1'b0;
        for (int i = `BOTTOM_FLOOR; i <= `TOP_FLOOR; i++) begin
            if (requests[i] && floor_t'(i) > current_floor) begin
                any_above = 1'b1;
            end
            if (requests[i] && floor_t'(i) < current_floor) begin
                any_below = 1'b1;
            end
        end
    end

    //////////////////////////////
    // Direction FSM
    //////////////////////////////

    // Reverse only once nothing is left ahead and something waits behind
    always_comb begin : direction_next
        next_dir = dir_state;
        case (dir_state)
            DIR_UP: begin
                if (!any_above && any_below) begin
                    next_dir = DIR_DOWN;
                end
            end
            DIR_DOWN: begin
                if (!any_below && any_above) begin
                    next_dir = DIR_UP;
                end
            end
            default: next_dir = DIR_UP;
        endcase
    end

    //////////////////////////////
    // SCAN target choice
    //////////////////////////////

    // Nearest requested floor in the travel direction, else stay put
    always_comb begin : target_scan
        next_target = current_floor;
        if (next_dir == DIR_UP) begin
            // Walk downward so the lowest floor above the car is kept
            for (int i = `TOP_FLOOR; i >= `BOTTOM_FLOOR; i--) begin
                if (requests[i] && floor_t'(i) > current_floor) begin
                    next_target = floor_t'(i);
                end
            end
        end else begin
            // Walk upward so the highest floor below the car is kept
            for (int i = `BOTTOM_FLOOR; i <= `TOP_FLOOR; i++) begin
                if (requests[i] && floor_t'(i) < current_floor) begin
                    next_target = floor_t'(i);
                end
            end
        end
    end

    assign next_activate = panel.power_on && !panel.emergency && !moving &&
                           (next_target != current_floor);

    //////////////////////////////
    // Arrival clear
    //////////////////////////////

    // One-hot of the parked floor, an out-of-range index clears nothing
    always_comb begin : arrival_clear
        service_clear = '0;
        if (stopped_powered) begin
            for (int i = 0; i < `NUM_FLOORS; i++) begin
                service_clear[i] = (floor_t'(i) == current_floor);
            end
        end
    end

    //////////////////////////////
    // Output registers
    //////////////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            dir_state  <= DIR_UP;
            target_q   <= floor_t'(`BOTTOM_FLOOR);
            activate_q <= 1'b0;
            doors      <= '0;
        end else begin
            // Target and direction are frozen while the car travels
            if (!moving) begin
                dir_state <= next_dir;
                target_q  <= next_target;
            end
            activate_q          <= next_activate;
            doors.open_allowed  <= stopped_powered && panel.door_open_btn;
            doors.close_allowed <= stopped_powered && panel.door_close_btn;
        end
    end

    assign command.target_floor = target_q;
    assign command.direction    = dir_state;
    assign command.activate     = activate_q;

endmodule

/* verilog/car_pkg.sv */
/*
 * Car interface structs
 * Status from the car, command to the car, door permits and panel controls
 */

package car_pkg;

    import floor_pkg::*;

    // Reported by the car motion logic
    typedef struct packed {
        floor_t current_floor;
        logic   moving;
    } car_status_t;

    // Sent to the car motion logic
    typedef struct packed {
        floor_t     target_floor;
        direction_t direction;
        logic       activate;
    } car_command_t;

    // Door requests granted while the car is stopped
    typedef struct packed {
        logic open_allowed;
        logic close_allowed;
    } door_permit_t;

    // Switches and buttons on the cab panel
    typedef struct packed {
        logic power_on;
        logic emergency;
        logic door_open_btn;
        logic door_close_btn;
    } panel_ctrl_t;

endpackage

/* verilog/elevator_macros.svh */
/*
 * Elevator sizing constants
 * Floor count, floor index width and the end floors of the shaft
 */

`ifndef ELEVATOR_MACROS_SVH
`define ELEVATOR_MACROS_SVH

// Eleven landings, floor 1 is index 0
`define NUM_FLOORS 11

// Bits needed for a floor index
`define FLOOR_W 4

// End floors of the shaft
`define BOTTOM_FLOOR 0
`define TOP_FLOOR 10

`endif

/* verilog/floor_pkg.sv */
/*
 * Floor types
 * Floor index, per-floor request mask and travel direction
 */

`include "elevator_macros.svh"

package floor_pkg;

    //////////////////////////////
    // Floor addressing
    //////////////////////////////

    // Index 0 is floor 1, index 10 is floor 11
    typedef logic [`FLOOR_W-1:0] floor_t;

    // One bit per landing
    typedef logic [`NUM_FLOORS-1:0] floor_mask_t;

    //////////////////////////////
    // Travel direction
    //////////////////////////////

    // Two-state direction machine, 1 means up
    typedef enum logic {
        DIR_DOWN = 1'b0,
        DIR_UP   = 1'b1
    } direction_t;

endpackage

/* verilog/floor_request_controller.sv */
/*
 * Floor request controller
 * Hall and cab request latches feeding one SCAN dispatcher
 */

`timescale 1ns/1ps

module floor_request_controller
    import floor_pkg::*;
    import car_pkg::*;
(
    input  logic         clock,
    input  logic         reset_n,
    input  floor_mask_t  hall_calls,
    input  floor_mask_t  cab_calls,
    input  car_status_t  car_status,
    input  panel_ctrl_t  panel,
    output floor_mask_t  hall_lights,
    output floor_mask_t  cab_lights,
    output car_command_t command,
    output door_permit_t doors
);

    // Arrival clear shared by both banks
    floor_mask_t service_clear;

    //////////////////////////////
    // Request banks
    //////////////////////////////

    // Landing call buttons
    request_latch hall_latch (
        .clock         (clock),
        .reset_n       (reset_n),
        .buttons       (hall_calls),
        .current_floor (car_status.current_floor),
        .panel         (panel),
        .service_clear (service_clear),
        .lights        (hall_lights)
    );

    // Destination buttons inside the cab
    request_latch cab_latch (
        .clock         (clock),
        .reset_n       (reset_n),
        .buttons       (cab_calls),
        .current_floor (car_status.current_floor),
        .panel         (panel),
        .service_clear (service_clear),
        .lights        (cab_lights)
    );

    //////////////////////////////
    // Dispatcher
    //////////////////////////////

    car_dispatcher dispatcher (
        .clock         (clock),
        .reset_n       (reset_n),
        .hall_lights   (hall_lights),
        .cab_lights    (cab_lights),
        .car_status    (car_status),
        .panel         (panel),
        .service_clear (service_clear),
        .command       (command),
        .doors         (doors)
    );

endmodule

/* verilog/request_latch.sv */
/*
 * Request latch for one bank of floor buttons
 * Turns button presses into request lights and clears them on arrival
 */

`timescale 1ns/1ps

`include "elevator_macros.svh"

module request_latch
    import floor_pkg::*;
    import car_pkg::*;
(
    input  logic        clock,
    input  logic        reset_n,
    input  floor_mask_t buttons,
    input  floor_t      current_floor,
    input  panel_ctrl_t panel,
    input  floor_mask_t service_clear,
    output floor_mask_t lights
);

    floor_mask_t accept;
    logic        panel_live;

    //////////////////////////////
    // Press qualification
    //////////////////////////////

    // Buttons are dead with power off or during an emergency stop
    assign panel_live = panel.power_on && !panel.emergency;

    // A press at the floor the car is on means nothing
    always_comb begin : press_accept
        accept = '0;
        if (panel_live) begin
            for (int i = 0; i < `NUM_FLOORS; i++) begin
                accept[i] = buttons[i] && (floor_t'(i) != current_floor);
            end
        end
    end

    //////////////////////////////
    // Light registers
    //////////////////////////////

    // Clear has priority over a new press on the same floor
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            lights <= '0;
        end else begin
            lights <= (lights | accept) & ~service_clear;
        end
    end

endmodule
